// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dual_issue_tb
FILELIST  := dual_issue.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := *** FAILED ***
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -F -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  dual_issue_pkg::alu_op_e op_i,
    input  dual_issue_pkg::word_t   a_i,
    input  dual_issue_pkg::word_t   b_i,
    output dual_issue_pkg::word_t   y_o
);
    import dual_issue_pkg::*;

    logic [4:0] sh;

    // shift distance from a, value from b
    assign sh = a_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_NOR:  y_o = ~(a_i | b_i);
            ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {31'b0, a_i < b_i};
            ALU_SLL:  y_o = b_i << sh;
            ALU_SRL:  y_o = b_i >> sh;
            ALU_SRA:  y_o = word_t'($signed(b_i) >>> sh);
            ALU_LUI:  y_o = {b_i[15:0], 16'h0000};
            default:  y_o = '0;
        endcase
    end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  dual_issue_pkg::word_t    instr_i,
    output dual_issue_pkg::decoded_t dec_o
);
    import dual_issue_pkg::*;

    word_t     imm_sext;
    word_t     imm_zext;
    reg_addr_t waddr;

    assign imm_sext = {{16{instr_i[15]}}, instr_i[15:0]};
    assign imm_zext = {16'h0000, instr_i[15:0]};

    always_comb begin
        dec_o           = '0;
        dec_o.alu_op    = ALU_NOP;
        dec_o.rs        = instr_i[25:21];
        dec_o.rt        = instr_i[20:16];
        dec_o.shamt     = instr_i[10:6];
        dec_o.reads_rs  = 1'b1;
        dec_o.use_imm   = 1'b1;
        dec_o.imm_value = imm_sext;
        waddr           = instr_i[20:16];

        case (opcode_e'(instr_i[31:26]))
            OP_SPECIAL: begin
                dec_o.use_imm  = 1'b0;
                dec_o.reads_rt = 1'b1;
                waddr          = instr_i[15:11];
                case (funct_e'(instr_i[5:0]))
                    FN_ADDU: dec_o.alu_op = ALU_ADD;
                    FN_SUBU: dec_o.alu_op = ALU_SUB;
                    FN_AND:  dec_o.alu_op = ALU_AND;
                    FN_OR:   dec_o.alu_op = ALU_OR;
                    FN_XOR:  dec_o.alu_op = ALU_XOR;
                    FN_NOR:  dec_o.alu_op = ALU_NOR;
                    FN_SLT:  dec_o.alu_op = ALU_SLT;
                    FN_SLTU: dec_o.alu_op = ALU_SLTU;
                    FN_SLL:  dec_o.alu_op = ALU_SLL;
                    FN_SRL:  dec_o.alu_op = ALU_SRL;
                    FN_SRA:  dec_o.alu_op = ALU_SRA;
                    default: dec_o.alu_op = ALU_NOP;
                endcase
                // shift amount comes from the shamt field, rs is ignored
                if (dec_o.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                    dec_o.use_shamt = 1'b1;
                    dec_o.reads_rs  = 1'b0;
                end
            end
            OP_ADDIU: dec_o.alu_op = ALU_ADD;
            OP_SLTI:  dec_o.alu_op = ALU_SLT;
            // sign extended, then compared unsigned
            OP_SLTIU: dec_o.alu_op = ALU_SLTU;
            OP_ANDI: begin
                dec_o.alu_op    = ALU_AND;
                dec_o.imm_value = imm_zext;
            end
            OP_ORI: begin
                dec_o.alu_op    = ALU_OR;
                dec_o.imm_value = imm_zext;
            end
            OP_XORI: begin
                dec_o.alu_op    = ALU_XOR;
                dec_o.imm_value = imm_zext;
            end
            OP_LUI: begin
                dec_o.alu_op    = ALU_LUI;
                dec_o.imm_value = imm_zext;
                dec_o.reads_rs  = 1'b0;
            end
            default: dec_o.alu_op = ALU_NOP;
        endcase

        // unknown words read nothing and write nothing
        if (dec_o.alu_op == ALU_NOP) begin
            dec_o.reads_rs = 1'b0;
            dec_o.reads_rt = 1'b0;
        end
        dec_o.reg_waddr = waddr;
        dec_o.reg_wen   = (dec_o.alu_op != ALU_NOP) && (waddr != '0);
    end

endmodule

// ==== dual_issue.f ====
dual_issue_pkg.sv
inst_fifo.sv
decoder.sv
regfile.sv
forward_unit.sv
issue_ctrl.sv
alu.sv
dual_issue_core.sv
dual_issue_chk.sv
dual_issue_tb.sv

// ==== dual_issue_chk.sv ====
`timescale 1ns/1ps

module dual_issue_chk (
    input logic                clk,
    input logic                rst_i,
    input logic                ok1_i,
    input logic                ok2_i,
    input logic                fifo_full_i,
    input logic                fifo_empty_i,
    input dual_issue_pkg::wb_t retire_master_i,
    input dual_issue_pkg::wb_t retire_slave_i
);

    // a second word only rides along with a first
    a_ok2_needs_ok1: assert property (@(posedge clk) disable iff (rst_i) ok2_i |-> ok1_i)
        else $error("second fetch strobe without the first");

    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst_i)
        ok1_i |-> !fifo_full_i)
        else $error("fetch wrote while the instruction FIFO was full");

    // reset clears the W registers one edge later
    a_reset_retire_quiet: assert property (@(posedge clk)
        rst_i |=> (!retire_master_i.wen && !retire_slave_i.wen))
        else $error("retire write enable high during reset");

    a_empty_full_exclusive: assert property (@(posedge clk) disable iff (rst_i)
        !(fifo_empty_i && fifo_full_i))
        else $error("instruction FIFO reports empty and full together");

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core #(
    parameter int FIFO_DEPTH = dual_issue_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  inst_data_ok1_i,
    input  logic                  inst_data_ok2_i,
    input  dual_issue_pkg::word_t inst_rdata1_i,
    input  dual_issue_pkg::word_t inst_rdata2_i,
    output logic                  fifo_full_o,
    output dual_issue_pkg::wb_t   retire_master_o,
    output dual_issue_pkg::wb_t   retire_slave_o
);
    import dual_issue_pkg::*;

    // D/E register contents, operands already selected
    typedef struct packed {
        alu_op_e   op;
        word_t     a;
        word_t     b;
        logic      wen;
        reg_addr_t waddr;
    } ex_t;

    // lane 0 is master, lane 1 is slave
    word_t      fifo_word [2];
    logic       fifo_empty;
    logic       fifo_almost_empty;
    logic [1:0] lane_issue;
    decoded_t   dec [2];
    word_t      rf_rs [2];
    word_t      rf_rt [2];
    word_t      fwd_rs [2];
    word_t      fwd_rt [2];
    ex_t        ex_d [2];
    ex_t        ex_q [2];
    word_t      alu_y [2];
    wb_t        e_wb [2];
    wb_t        w_q [2];

    inst_fifo #(.DEPTH(FIFO_DEPTH)) u_inst_fifo (
        .clk            (clk),
        .rst_i          (rst_i),
        .we1_i          (inst_data_ok1_i),
        .we2_i          (inst_data_ok2_i),
        .wdata1_i       (inst_rdata1_i),
        .wdata2_i       (inst_rdata2_i),
        .pop1_i         (lane_issue[0]),
        .pop2_i         (lane_issue[1]),
        .head_o         (fifo_word[0]),
        .second_o       (fifo_word[1]),
        .empty_o        (fifo_empty),
        .almost_empty_o (fifo_almost_empty),
        .full_o         (fifo_full_o)
    );

    issue_ctrl u_issue_ctrl (
        .empty_i        (fifo_empty),
        .almost_empty_i (fifo_almost_empty),
        .dec_master_i   (dec[0]),
        .dec_slave_i    (dec[1]),
        .issue_master_o (lane_issue[0]),
        .issue_slave_o  (lane_issue[1])
    );

    regfile u_regfile (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_master_i (w_q[0]),
        .wb_slave_i  (w_q[1]),
        .ra_m_rs_i   (dec[0].rs),
        .ra_m_rt_i   (dec[0].rt),
        .ra_s_rs_i   (dec[1].rs),
        .ra_s_rt_i   (dec[1].rt),
        .rd_m_rs_o   (rf_rs[0]),
        .rd_m_rt_o   (rf_rt[0]),
        .rd_s_rs_o   (rf_rs[1]),
        .rd_s_rt_o   (rf_rt[1])
    );

    forward_unit u_forward_unit (
        .dec_master_i (dec[0]),
        .dec_slave_i  (dec[1]),
        .rf_m_rs_i    (rf_rs[0]),
        .rf_m_rt_i    (rf_rt[0]),
        .rf_s_rs_i    (rf_rs[1]),
        .rf_s_rt_i    (rf_rt[1]),
        .e_master_i   (e_wb[0]),
        .e_slave_i    (e_wb[1]),
        .m_rs_o       (fwd_rs[0]),
        .m_rt_o       (fwd_rt[0]),
        .s_rs_o       (fwd_rs[1]),
        .s_rt_o       (fwd_rt[1])
    );

    for (genvar l = 0; l < 2; l++) begin : g_lane
        decoder u_decoder (
            .instr_i (fifo_word[l]),
            .dec_o   (dec[l])
        );

        assign ex_d[l] = '{
            op:    dec[l].alu_op,
            a:     dec[l].use_shamt ? {27'b0, dec[l].shamt} : fwd_rs[l],
            b:     dec[l].use_imm ? dec[l].imm_value : fwd_rt[l],
            wen:   dec[l].reg_wen,
            waddr: dec[l].reg_waddr
        };

        // a lane that does not issue carries a bubble into E
        always_ff @(posedge clk) begin
            ex_q[l] <= ex_d[l];
            if (rst_i || !lane_issue[l]) begin
                ex_q[l].wen <= 1'b0;
                ex_q[l].op  <= ALU_NOP;
            end
        end

        alu u_alu (
            .op_i (ex_q[l].op),
            .a_i  (ex_q[l].a),
            .b_i  (ex_q[l].b),
            .y_o  (alu_y[l])
        );

        assign e_wb[l] = '{wen: ex_q[l].wen, waddr: ex_q[l].waddr, wdata: alu_y[l]};

        always_ff @(posedge clk) begin
            w_q[l] <= e_wb[l];
            if (rst_i) begin
                w_q[l].wen <= 1'b0;
            end
        end
    end

    assign retire_master_o = w_q[0];
    assign retire_slave_o  = w_q[1];

endmodule

// ==== dual_issue_pkg.sv ====
package dual_issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_NOP
    } alu_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        logic      reads_rs;
        logic      reads_rt;
        logic [4:0] shamt;
        word_t     imm_value;
        logic      use_shamt;
        logic      use_imm;
        logic      reg_wen;
        reg_addr_t reg_waddr;
    } decoded_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

    localparam int DEFAULT_FIFO_DEPTH = 8;

endpackage

// ==== dual_issue_tb.sv ====
`timescale 1ns/1ps

module dual_issue_tb;
    import dual_issue_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int N_ROWS         = 30;
    localparam int CYCLES_PER_ROW = 20;
    // small queue so fetch runs into the full level
    localparam int TB_FIFO_DEPTH  = 4;

    typedef struct packed {
        word_t     instr;
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } row_t;

    logic  clk;
    logic  rst_i;
    logic  inst_data_ok1_i;
    logic  inst_data_ok2_i;
    word_t inst_rdata1_i;
    word_t inst_rdata2_i;
    logic  fifo_full_o;
    wb_t   retire_master_o;
    wb_t   retire_slave_o;

    row_t  rows [N_ROWS];
    word_t model_regs [32];
    wb_t   exp_q [$];
    int    n_rows = 0;
    int    n_expected = 0;
    int    n_retired = 0;
    logic  run_done = 1'b0;

    dual_issue_core #(.FIFO_DEPTH(TB_FIFO_DEPTH)) dual_issue_core_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .inst_data_ok1_i (inst_data_ok1_i),
        .inst_data_ok2_i (inst_data_ok2_i),
        .inst_rdata1_i   (inst_rdata1_i),
        .inst_rdata2_i   (inst_rdata2_i),
        .fifo_full_o     (fifo_full_o),
        .retire_master_o (retire_master_o),
        .retire_slave_o  (retire_slave_o)
    );

    bind dual_issue_core dual_issue_chk u_dual_issue_chk (
        .clk             (clk),
        .rst_i           (rst_i),
        .ok1_i           (inst_data_ok1_i),
        .ok2_i           (inst_data_ok2_i),
        .fifo_full_i     (fifo_full_o),
        .fifo_empty_i    (fifo_empty),
        .retire_master_i (retire_master_o),
        .retire_slave_i  (retire_slave_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        run_done = 1'b1;
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic word_t r_word(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
                                     reg_addr_t rt, logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_row(word_t instr, logic wen, reg_addr_t waddr, word_t wdata);
        rows[n_rows] = '{instr: instr, wen: wen, waddr: waddr, wdata: wdata};
        n_rows++;
    endtask

    // start state is all registers zero
    task automatic load_table();
        add_row(i_word(6'h09, 5'd1, 5'd0, 16'h0005), 1'b1, 5'd1, 32'h0000_0005);
        add_row(i_word(6'h09, 5'd2, 5'd0, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd);
        add_row(r_word(6'h21, 5'd3, 5'd1, 5'd2, 5'd0), 1'b1, 5'd3, 32'h0000_0002);
        add_row(r_word(6'h23, 5'd4, 5'd1, 5'd2, 5'd0), 1'b1, 5'd4, 32'h0000_0008);
        add_row(r_word(6'h24, 5'd5, 5'd2, 5'd1, 5'd0), 1'b1, 5'd5, 32'h0000_0005);
        add_row(r_word(6'h25, 5'd6, 5'd1, 5'd2, 5'd0), 1'b1, 5'd6, 32'hffff_fffd);
        add_row(r_word(6'h26, 5'd7, 5'd1, 5'd2, 5'd0), 1'b1, 5'd7, 32'hffff_fff8);
        add_row(r_word(6'h27, 5'd8, 5'd1, 5'd2, 5'd0), 1'b1, 5'd8, 32'h0000_0002);
        add_row(r_word(6'h2a, 5'd9, 5'd2, 5'd1, 5'd0), 1'b1, 5'd9, 32'h0000_0001);
        add_row(r_word(6'h2b, 5'd10, 5'd2, 5'd1, 5'd0), 1'b1, 5'd10, 32'h0000_0000);
        add_row(r_word(6'h00, 5'd11, 5'd0, 5'd1, 5'd4), 1'b1, 5'd11, 32'h0000_0050);
        add_row(r_word(6'h02, 5'd12, 5'd0, 5'd2, 5'd8), 1'b1, 5'd12, 32'h00ff_ffff);
        add_row(r_word(6'h03, 5'd13, 5'd0, 5'd2, 5'd1), 1'b1, 5'd13, 32'hffff_fffe);
        add_row(i_word(6'h0f, 5'd14, 5'd0, 16'h8001), 1'b1, 5'd14, 32'h8001_0000);
        add_row(i_word(6'h0c, 5'd15, 5'd2, 16'hff0f), 1'b1, 5'd15, 32'h0000_ff0d);
        add_row(i_word(6'h0d, 5'd16, 5'd1, 16'h8000), 1'b1, 5'd16, 32'h0000_8005);
        add_row(i_word(6'h0e, 5'd17, 5'd2, 16'hffff), 1'b1, 5'd17, 32'hffff_0002);
        add_row(i_word(6'h0a, 5'd18, 5'd2, 16'hfffe), 1'b1, 5'd18, 32'h0000_0001);
        add_row(i_word(6'h0b, 5'd19, 5'd1, 16'hffff), 1'b1, 5'd19, 32'h0000_0001);
        // r0 target and an undefined opcode, neither writes
        add_row(i_word(6'h09, 5'd0, 5'd1, 16'h0007), 1'b0, 5'd0, 32'h0000_0000);
        add_row(32'hfc00_0000, 1'b0, 5'd0, 32'h0000_0000);
        add_row(r_word(6'h21, 5'd20, 5'd0, 5'd1, 5'd0), 1'b1, 5'd20, 32'h0000_0005);
        add_row(i_word(6'h09, 5'd21, 5'd0, 16'h0011), 1'b1, 5'd21, 32'h0000_0011);
        add_row(i_word(6'h09, 5'd21, 5'd0, 16'h0022), 1'b1, 5'd21, 32'h0000_0022);
        add_row(r_word(6'h21, 5'd22, 5'd21, 5'd0, 5'd0), 1'b1, 5'd22, 32'h0000_0022);
        add_row(i_word(6'h09, 5'd23, 5'd22, 16'h0001), 1'b1, 5'd23, 32'h0000_0023);
        add_row(i_word(6'h09, 5'd23, 5'd23, 16'h0001), 1'b1, 5'd23, 32'h0000_0024);
        add_row(r_word(6'h00, 5'd24, 5'd0, 5'd23, 5'd1), 1'b1, 5'd24, 32'h0000_0048);
        add_row(r_word(6'h23, 5'd25, 5'd24, 5'd23, 5'd0), 1'b1, 5'd25, 32'h0000_0024);
        add_row(r_word(6'h2b, 5'd26, 5'd0, 5'd25, 5'd0), 1'b1, 5'd26, 32'h0000_0001);
    endtask

    // in-order MIPS ALU semantics on the model register array
    task automatic model_step(input word_t ins, output wb_t res);
        logic [5:0] op;
        logic [5:0] fn;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      zimm;
        logic       known;
        op    = ins[31:26];
        fn    = ins[5:0];
        a     = model_regs[ins[25:21]];
        b     = model_regs[ins[20:16]];
        simm  = {{16{ins[15]}}, ins[15:0]};
        zimm  = {16'h0000, ins[15:0]};
        known = 1'b1;
        res   = '0;
        res.waddr = (op == 6'h00) ? ins[15:11] : ins[20:16];
        case (op)
            6'h00: begin
                case (fn)
                    6'h00: res.wdata = b << ins[10:6];
                    6'h02: res.wdata = b >> ins[10:6];
                    6'h03: res.wdata = $signed(b) >>> ins[10:6];
                    6'h21: res.wdata = a + b;
                    6'h23: res.wdata = a - b;
                    6'h24: res.wdata = a & b;
                    6'h25: res.wdata = a | b;
                    6'h26: res.wdata = a ^ b;
                    6'h27: res.wdata = ~(a | b);
                    6'h2a: res.wdata = {31'b0, $signed(a) < $signed(b)};
                    6'h2b: res.wdata = {31'b0, a < b};
                    default: known = 1'b0;
                endcase
            end
            6'h09: res.wdata = a + simm;
            6'h0a: res.wdata = {31'b0, $signed(a) < $signed(simm)};
            6'h0b: res.wdata = {31'b0, a < simm};
            6'h0c: res.wdata = a & zimm;
            6'h0d: res.wdata = a | zimm;
            6'h0e: res.wdata = a ^ zimm;
            6'h0f: res.wdata = {ins[15:0], 16'h0000};
            default: known = 1'b0;
        endcase
        res.wen = known && (res.waddr != 5'd0);
        if (res.wen) begin
            model_regs[res.waddr] = res.wdata;
        end
    endtask

    task automatic check_retire(input string name, input wb_t got);
        wb_t exp;
        assert (exp_q.size() > 0)
            else fail_run($sformatf("%s wrote r%0d after the expected writes ran out",
                                    name, got.waddr));
        exp = exp_q.pop_front();
        assert (got.waddr == exp.waddr)
            else fail_run($sformatf("Error: %s.waddr = 0x%02h, expected 0x%02h",
                                    name, got.waddr, exp.waddr));
        assert (got.wdata == exp.wdata)
            else fail_run($sformatf("Error: %s.wdata = 0x%08h, expected 0x%08h",
                                    name, got.wdata, exp.wdata));
        n_retired++;
    endtask

    // master first, that is program order within a pair
    always @(negedge clk) begin
        if (!rst_i) begin
            if (retire_master_o.wen) begin
                check_retire("retire_master_o", retire_master_o);
            end
            if (retire_slave_o.wen) begin
                check_retire("retire_slave_o", retire_slave_o);
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + N_ROWS * CYCLES_PER_ROW) @(posedge clk);
        fail_run("timeout: not every expected register write retired in time");
    end

    initial begin
        wb_t         res;
        int          idx;
        logic        full_seen;
        int          occ_max;
        int          n_flight;

        void'($urandom(12));
        rst_i           <= 1'b1;
        inst_data_ok1_i <= 1'b0;
        inst_data_ok2_i <= 1'b0;
        inst_rdata1_i   <= '0;
        inst_rdata2_i   <= '0;

        load_table();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            model_step(rows[i].instr, res);
            assert (res.wen == rows[i].wen &&
                    (!res.wen || (res.waddr == rows[i].waddr && res.wdata == rows[i].wdata)))
                else fail_run($sformatf(
                    "Error: model row %0d wen=%0h waddr=0x%02h wdata=0x%08h, table 0x%02h 0x%08h",
                    i, res.wen, res.waddr, res.wdata, rows[i].waddr, rows[i].wdata));
            if (res.wen) begin
                exp_q.push_back(res);
            end
        end
        n_expected = exp_q.size();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        // a push lands one edge after it is driven
        // occ_max bounds the queue level at that edge
        idx      = 0;
        occ_max  = 0;
        n_flight = 0;
        while (idx < N_ROWS) begin
            @(negedge clk);
            full_seen = fifo_full_o;
            assert (!full_seen || occ_max > TB_FIFO_DEPTH - 2)
                else fail_run($sformatf(
                    "Error: fifo_full_o = 0x1, expected 0x0 with at most %0d words queued",
                    occ_max));
            if (!full_seen && occ_max > TB_FIFO_DEPTH - 2) begin
                occ_max = TB_FIFO_DEPTH - 2;
            end
            // the master pops at least one word whenever the queue holds any
            occ_max = ((occ_max > 0) ? occ_max - 1 : 0) + n_flight;
            @(posedge clk);
            if (full_seen || occ_max > TB_FIFO_DEPTH - 2 || ($urandom % 4) == 0) begin
                inst_data_ok1_i <= 1'b0;
                inst_data_ok2_i <= 1'b0;
                n_flight = 0;
            end else begin
                inst_data_ok1_i <= 1'b1;
                inst_rdata1_i   <= rows[idx].instr;
                if (idx + 1 < N_ROWS && ($urandom % 2) == 1) begin
                    inst_data_ok2_i <= 1'b1;
                    inst_rdata2_i   <= rows[idx + 1].instr;
                    idx = idx + 2;
                    n_flight = 2;
                end else begin
                    inst_data_ok2_i <= 1'b0;
                    idx = idx + 1;
                    n_flight = 1;
                end
            end
        end
        @(posedge clk);
        inst_data_ok1_i <= 1'b0;
        inst_data_ok2_i <= 1'b0;

        while (n_retired < n_expected) begin
            @(posedge clk);
        end
        // a few more edges to catch stray writes
        repeat (4) @(posedge clk);
        if (n_retired == n_expected && exp_q.size() == 0) begin
            run_done = 1'b1;
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run($sformatf("retired %0d register writes, expected %0d",
                               n_retired, n_expected));
        end
    end

    final begin
        if (!run_done) begin
            $display("*** FAILED ***");
        end
    end

endmodule

// ==== forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit (
    input  dual_issue_pkg::decoded_t dec_master_i,
    input  dual_issue_pkg::decoded_t dec_slave_i,
    input  dual_issue_pkg::word_t    rf_m_rs_i,
    input  dual_issue_pkg::word_t    rf_m_rt_i,
    input  dual_issue_pkg::word_t    rf_s_rs_i,
    input  dual_issue_pkg::word_t    rf_s_rt_i,
    input  dual_issue_pkg::wb_t      e_master_i,
    input  dual_issue_pkg::wb_t      e_slave_i,
    output dual_issue_pkg::word_t    m_rs_o,
    output dual_issue_pkg::word_t    m_rt_o,
    output dual_issue_pkg::word_t    s_rs_o,
    output dual_issue_pkg::word_t    s_rt_o
);
    import dual_issue_pkg::*;

    // E slave over E master over regfile
    function automatic word_t resolve(reg_addr_t ra, word_t rf_val, wb_t e_m, wb_t e_s);
        word_t v;
        v = rf_val;
        if (ra != '0 && e_m.wen && e_m.waddr == ra) begin
            v = e_m.wdata;
        end
        if (ra != '0 && e_s.wen && e_s.waddr == ra) begin
            v = e_s.wdata;
        end
        return v;
    endfunction

    assign m_rs_o = resolve(dec_master_i.rs, rf_m_rs_i, e_master_i, e_slave_i);
    assign m_rt_o = resolve(dec_master_i.rt, rf_m_rt_i, e_master_i, e_slave_i);
    assign s_rs_o = resolve(dec_slave_i.rs, rf_s_rs_i, e_master_i, e_slave_i);
    assign s_rt_o = resolve(dec_slave_i.rt, rf_s_rt_i, e_master_i, e_slave_i);

endmodule

// ==== inst_fifo.sv ====
`timescale 1ns/1ps

module inst_fifo #(
    parameter int DEPTH = dual_issue_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  we1_i,
    input  logic                  we2_i,
    input  dual_issue_pkg::word_t wdata1_i,
    input  dual_issue_pkg::word_t wdata2_i,
    input  logic                  pop1_i,
    input  logic                  pop2_i,
    output dual_issue_pkg::word_t head_o,
    output dual_issue_pkg::word_t second_o,
    output logic                  empty_o,
    output logic                  almost_empty_o,
    output logic                  full_o
);
    import dual_issue_pkg::*;

    // pointers wrap naturally, so DEPTH is a power of two
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    word_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [1:0]    n_wr;
    logic [1:0]    n_rd;

    assign n_wr = {1'b0, we1_i} + {1'b0, we2_i};
    assign n_rd = {1'b0, pop1_i} + {1'b0, pop2_i};

    // word2 lands right behind word1
    always_ff @(posedge clk) begin
        if (we1_i) begin
            mem[wr_ptr] <= wdata1_i;
        end
        if (we2_i) begin
            mem[wr_ptr + AW'(1)] <= wdata2_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + AW'(n_wr);
            rd_ptr <= rd_ptr + AW'(n_rd);
            count  <= count + CW'(n_wr) - CW'(n_rd);
        end
    end

    assign head_o   = mem[rd_ptr];
    assign second_o = mem[rd_ptr + AW'(1)];

    assign empty_o        = (count == '0);
    assign almost_empty_o = (count == CW'(1));
    // fetch may deliver a pair, so keep two slots in hand
    assign full_o         = (count > CW'(DEPTH - 2));

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                     empty_i,
    input  logic                     almost_empty_i,
    input  dual_issue_pkg::decoded_t dec_master_i,
    input  dual_issue_pkg::decoded_t dec_slave_i,
    output logic                     issue_master_o,
    output logic                     issue_slave_o
);

    logic rs_dep;
    logic rt_dep;
    logic raw_hazard;

    // slave source matching the master destination
    assign rs_dep = dec_slave_i.reads_rs && (dec_slave_i.rs == dec_master_i.reg_waddr);
    assign rt_dep = dec_slave_i.reads_rt && (dec_slave_i.rt == dec_master_i.reg_waddr);

    assign raw_hazard = dec_master_i.reg_wen && (rs_dep || rt_dep);

    assign issue_master_o = !empty_i;

    // needs a second word in the queue; a dependent slave waits one cycle
    // and goes out as next cycle's master
    assign issue_slave_o = !empty_i && !almost_empty_i && !raw_hazard;

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                      clk,
    input  logic                      rst_i,
    input  dual_issue_pkg::wb_t       wb_master_i,
    input  dual_issue_pkg::wb_t       wb_slave_i,
    input  dual_issue_pkg::reg_addr_t ra_m_rs_i,
    input  dual_issue_pkg::reg_addr_t ra_m_rt_i,
    input  dual_issue_pkg::reg_addr_t ra_s_rs_i,
    input  dual_issue_pkg::reg_addr_t ra_s_rt_i,
    output dual_issue_pkg::word_t     rd_m_rs_o,
    output dual_issue_pkg::word_t     rd_m_rt_o,
    output dual_issue_pkg::word_t     rd_s_rs_o,
    output dual_issue_pkg::word_t     rd_s_rt_o
);
    import dual_issue_pkg::*;

    // entry 0 is cleared at reset and never written
    word_t regs [32];

    // same-cycle W writes bypass the array, slave is newer
    function automatic word_t read_port(reg_addr_t ra, wb_t wm, wb_t ws);
        word_t v;
        v = regs[ra];
        if (ra != '0 && wm.wen && wm.waddr == ra) begin
            v = wm.wdata;
        end
        if (ra != '0 && ws.wen && ws.waddr == ra) begin
            v = ws.wdata;
        end
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_master_i.wen && wb_master_i.waddr != '0) begin
                regs[wb_master_i.waddr] <= wb_master_i.wdata;
            end
            // later in program order, so it overrides on a clash
            if (wb_slave_i.wen && wb_slave_i.waddr != '0) begin
                regs[wb_slave_i.waddr] <= wb_slave_i.wdata;
            end
        end
    end

    always_comb begin
        rd_m_rs_o = read_port(ra_m_rs_i, wb_master_i, wb_slave_i);
        rd_m_rt_o = read_port(ra_m_rt_i, wb_master_i, wb_slave_i);
        rd_s_rs_o = read_port(ra_s_rs_i, wb_master_i, wb_slave_i);
        rd_s_rt_o = read_port(ra_s_rt_i, wb_master_i, wb_slave_i);
    end

endmodule
